//--- common/switch_defines.svh
`ifndef SWITCH_DEFINES_SVH
`define SWITCH_DEFINES_SVH

`define NUM_PORTS     4
`define PAGE_WORDS    8
`define NUM_PAGES     64
`define MAX_PKT_WORDS 64
`define DESC_DEPTH    8

// derived widths
`define PAGE_W        6
`define PORT_W        2

`endif

//--- common/switch_pkg.sv
`include "switch_defines.svh"

package switch_pkg;

    typedef logic [`PAGE_WORDS-1:0][15:0] page_t;

    // header word, dest in the low bits
    typedef struct packed {
        logic [8:0] length;
        logic [2:0] prior;
        logic [3:0] dest;
    } pkt_hdr_t;

    typedef struct packed {
        logic [`PAGE_W-1:0] head_page;
        logic [8:0]         length;
        logic [`PORT_W-1:0] dest;
    } pkt_desc_t;

    typedef enum logic [1:0] {W_IDLE, W_WRITE, W_LINK} wr_state_t;

    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_CHECK, R_SEND} rd_state_t;

    // round-robin pick, returns {valid, index}; lowest offset from ptr wins
    function automatic logic [`PORT_W:0] rr_pick(input logic [`NUM_PORTS-1:0] req,
                                                 input logic [`PORT_W-1:0] ptr);
        logic [`PORT_W-1:0] idx;
        rr_pick = '0;
        for (int i = `NUM_PORTS - 1; i >= 0; i--) begin
            idx = ptr + i[`PORT_W-1:0];
            if (req[idx]) begin
                rr_pick = {1'b1, idx};
            end
        end
    endfunction

endpackage

//--- common/switch_ifs.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

// one buffered page, frontend to writer
interface page_if
    import switch_pkg::*;
();
    logic       vld;
    page_t      data;
    logic       last;
    pkt_hdr_t   hdr;
    logic [3:0] word_count;
    logic       take;

    modport src (output vld, data, last, hdr, word_count, input take);
    modport dst (input vld, data, last, hdr, word_count, output take);
endinterface

// finished packet descriptors, writer to reader
interface desc_if
    import switch_pkg::*;
();
    logic                  push;
    pkt_desc_t             desc;
    logic [`NUM_PORTS-1:0] room;

    modport src (output push, desc, input room);
    modport dst (input push, desc, output room);
endinterface

//--- frontend/port_frontend.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module port_frontend
    import switch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_sop,
    input  logic        wr_eop,
    input  logic        wr_vld,
    input  logic [15:0] wr_data,
    output logic        full,
    page_if.src         pg,
    input  logic        space_low
);
    page_t      page_buf [2];
    pkt_hdr_t   page_hdr [2];
    logic [3:0] page_wc [2];
    logic [1:0] page_last;
    logic [1:0] held;
    logic       fill_sel;
    logic       out_sel;
    logic [2:0] widx;
    logic       page_end;
    logic       in_pkt;
    logic [8:0] pkt_cnt;
    pkt_hdr_t   hdr_in;
    pkt_hdr_t   cur_hdr;

    assign hdr_in   = pkt_hdr_t'(wr_data);
    assign page_end = wr_eop || (widx == 3'(`PAGE_WORDS - 1));
    assign full     = (held[0] && held[1]) || space_low;

    assign pg.vld        = held[out_sel];
    assign pg.data       = page_buf[out_sel];
    assign pg.last       = page_last[out_sel];
    assign pg.hdr        = page_hdr[out_sel];
    assign pg.word_count = page_wc[out_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            held     <= '0;
            fill_sel <= 1'b0;
            out_sel  <= 1'b0;
            widx     <= '0;
            in_pkt   <= 1'b0;
            pkt_cnt  <= '0;
        end else begin
            if (pg.vld && pg.take) begin
                held[out_sel] <= 1'b0;
                out_sel       <= ~out_sel;
            end
            if (wr_vld) begin
                in_pkt  <= !wr_eop;
                pkt_cnt <= wr_sop ? 9'd1 : pkt_cnt + 9'd1;
                widx    <= page_end ? 3'd0 : widx + 3'd1;
                // page complete, hand it over and switch buffers
                if (page_end) begin
                    held[fill_sel] <= 1'b1;
                    fill_sel       <= ~fill_sel;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            if (widx == 3'd0) begin
                page_buf[fill_sel] <= '0;
            end
            page_buf[fill_sel][widx] <= wr_data;
            page_hdr[fill_sel]       <= wr_sop ? hdr_in : cur_hdr;
            page_last[fill_sel]      <= wr_eop;
            page_wc[fill_sel]        <= {1'b0, widx} + 4'd1;
            if (wr_sop) begin
                cur_hdr <= hdr_in;
            end
        end
    end

    a_no_word_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_vld |-> !full);

    a_sop_at_start: assert property (@(posedge clk) disable iff (rst)
        wr_vld && wr_sop |-> !in_pkt);

    // header length counts the header word too
    a_len_at_eop: assert property (@(posedge clk) disable iff (rst)
        wr_vld && wr_eop |->
            (wr_sop ? hdr_in.length == 9'd1 : cur_hdr.length == pkt_cnt + 9'd1));

endmodule

//--- ecc/ecc_encoder.sv
`timescale 1ns/100ps

module ecc_encoder
    import switch_pkg::*;
(
    input  page_t      data,
    output logic [7:0] code
);
    logic [127:0] bits;

    assign bits = data;

    // codeword positions 1..136, check bits sit at the powers of two
    always_comb begin
        int k;
        code = '0;
        k    = 0;
        for (int p = 1; p <= 136; p++) begin
            if ((p & (p - 1)) != 0) begin
                for (int b = 0; b < 8; b++) begin
                    if (p[b]) begin
                        code[b] = code[b] ^ bits[k];
                    end
                end
                k++;
            end
        end
    end

endmodule

//--- ecc/ecc_decoder.sv
`timescale 1ns/100ps

module ecc_decoder
    import switch_pkg::*;
(
    input  page_t      data,
    input  logic [7:0] code,
    output page_t      fixed,
    output logic       corrected
);
    logic [7:0]   recomputed;
    logic [7:0]   syndrome;
    logic [127:0] bits;
    logic [127:0] fixed_bits;

    assign bits = data;

    ecc_encoder u_ecc_encoder (
        .data (data),
        .code (recomputed)
    );

    assign syndrome = recomputed ^ code;

    // syndrome is the position of the flipped bit
    always_comb begin
        int k;
        fixed_bits = bits;
        corrected  = 1'b0;
        k          = 0;
        for (int p = 1; p <= 136; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (syndrome == p[7:0]) begin
                    fixed_bits[k] = ~bits[k];
                    corrected     = 1'b1;
                end
                k++;
            end
        end
    end

    assign fixed = fixed_bits;

endmodule

//--- rtl/page_store.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module page_store
    import switch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc,
    output logic [`PAGE_W-1:0] alloc_page,
    output logic [`PAGE_W:0]   free_cnt,
    input  logic               wr_en,
    input  logic [`PAGE_W-1:0] wr_page,
    input  page_t              wr_data,
    input  logic [7:0]         wr_code,
    input  logic               link_en,
    input  logic [`PAGE_W-1:0] link_from,
    input  logic [`PAGE_W-1:0] link_to,
    input  logic [`PAGE_W-1:0] rd_page,
    output page_t              rd_data,
    output logic [7:0]         rd_code,
    output logic [`PAGE_W-1:0] rd_next,
    input  logic               release_en,
    input  logic [`PAGE_W-1:0] release_page
);
    page_t              page_mem [`NUM_PAGES];
    logic [7:0]         ecc_mem [`NUM_PAGES];
    logic [`PAGE_W-1:0] jump_mem [`NUM_PAGES];
    logic [`PAGE_W-1:0] free_list [`NUM_PAGES];
    logic [`PAGE_W-1:0] free_head;
    logic [`PAGE_W-1:0] free_tail;

    assign alloc_page = free_list[free_head];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            page_mem[wr_page] <= wr_data;
            ecc_mem[wr_page]  <= wr_code;
        end
        if (link_en) begin
            jump_mem[link_from] <= link_to;
        end
        rd_data <= page_mem[rd_page];
        rd_code <= ecc_mem[rd_page];
        rd_next <= jump_mem[rd_page];
    end

    // free list holds every page after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `NUM_PAGES; p++) begin
                free_list[p] <= p[`PAGE_W-1:0];
            end
        end else if (release_en) begin
            free_list[free_tail] <= release_page;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_head <= '0;
            free_tail <= '0;
            free_cnt  <= (`PAGE_W+1)'(`NUM_PAGES);
        end else begin
            if (alloc) begin
                free_head <= free_head + 1'b1;
            end
            if (release_en) begin
                free_tail <= free_tail + 1'b1;
            end
            free_cnt <= free_cnt + (`PAGE_W+1)'(release_en) - (`PAGE_W+1)'(alloc);
        end
    end

    a_alloc_not_empty: assert property (@(posedge clk) disable iff (rst)
        alloc |-> free_cnt != '0);

endmodule

//--- rtl/page_writer.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module page_writer
    import switch_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    page_if.dst                pg [`NUM_PORTS],
    output logic               alloc,
    input  logic [`PAGE_W-1:0] alloc_page,
    input  logic [`PAGE_W:0]   free_cnt,
    output logic               wr_en,
    output logic [`PAGE_W-1:0] wr_page,
    output page_t              wr_data,
    output logic [7:0]         wr_code,
    output logic               link_en,
    output logic [`PAGE_W-1:0] link_from,
    output logic [`PAGE_W-1:0] link_to,
    desc_if.src                dq,
    input  logic               err_inject
);
    wr_state_t             state;
    logic [`NUM_PORTS-1:0] req;
    logic [`NUM_PORTS-1:0] take;
    page_t                 pg_data [`NUM_PORTS];
    pkt_hdr_t              pg_hdr [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] pg_last;
    logic [3:0]            pg_wc [`NUM_PORTS];
    logic [`PORT_W:0]      pick;
    logic [`PORT_W-1:0]    pick_port;
    logic                  start;
    logic [`PORT_W-1:0]    rr_ptr;
    logic [`PORT_W-1:0]    cur_port;
    logic [`PAGE_W-1:0]    cur_page;
    page_t                 page_q;
    pkt_hdr_t              hdr_q;
    logic                  last_q;
    logic [3:0]            wc_q;
    logic [`NUM_PORTS-1:0] in_pkt;
    logic [`PAGE_W-1:0]    prev_page [`NUM_PORTS];
    logic [`PAGE_W-1:0]    head_page [`NUM_PORTS];
    logic [8:0]            len_acc [`NUM_PORTS];
    logic [8:0]            pkt_len;
    logic [`PAGE_W-1:0]    pkt_head;
    pkt_desc_t             desc_q;
    logic [7:0]            code;

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
        assign req[i]     = pg[i].vld;
        assign pg_data[i] = pg[i].data;
        assign pg_hdr[i]  = pg[i].hdr;
        assign pg_last[i] = pg[i].last;
        assign pg_wc[i]   = pg[i].word_count;
        assign pg[i].take = take[i];
    end

    assign pick      = rr_pick(req, rr_ptr);
    assign pick_port = pick[`PORT_W-1:0];
    assign start     = (state == W_IDLE) && pick[`PORT_W] && (free_cnt != '0);
    assign alloc     = start;

    always_comb begin
        take            = '0;
        take[pick_port] = start;
    end

    ecc_encoder u_ecc_encoder (
        .data (page_q),
        .code (code)
    );

    // error injection lands after the code is computed
    always_comb begin
        wr_data       = page_q;
        wr_data[0][0] = page_q[0][0] ^ err_inject;
    end

    assign wr_en     = (state == W_WRITE);
    assign wr_page   = cur_page;
    assign wr_code   = code;
    assign link_en   = wr_en && in_pkt[cur_port];
    assign link_from = prev_page[cur_port];
    assign link_to   = cur_page;
    assign pkt_len   = (in_pkt[cur_port] ? len_acc[cur_port] : 9'd0) + {5'd0, wc_q};
    assign pkt_head  = in_pkt[cur_port] ? head_page[cur_port] : cur_page;

    assign dq.push = (state == W_LINK) && dq.room[desc_q.dest];
    assign dq.desc = desc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= W_IDLE;
            rr_ptr <= '0;
            in_pkt <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (start) begin
                        state  <= W_WRITE;
                        rr_ptr <= pick_port + 1'b1;
                    end
                end
                W_WRITE: begin
                    in_pkt[cur_port] <= !last_q;
                    state            <= last_q ? W_LINK : W_IDLE;
                end
                W_LINK: begin
                    if (dq.push) begin
                        state <= W_IDLE;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_port <= pick_port;
            cur_page <= alloc_page;
            page_q   <= pg_data[pick_port];
            hdr_q    <= pg_hdr[pick_port];
            last_q   <= pg_last[pick_port];
            wc_q     <= pg_wc[pick_port];
        end
        if (state == W_WRITE) begin
            prev_page[cur_port] <= cur_page;
            head_page[cur_port] <= pkt_head;
            len_acc[cur_port]   <= pkt_len;
            desc_q.head_page    <= pkt_head;
            desc_q.length       <= pkt_len;
            desc_q.dest         <= hdr_q.dest[`PORT_W-1:0];
        end
    end

endmodule

//--- rtl/page_reader.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module page_reader
    import switch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    desc_if.dst                         dq,
    output logic [`PAGE_W-1:0]          rd_page,
    input  page_t                       rd_data,
    input  logic [7:0]                  rd_code,
    input  logic [`PAGE_W-1:0]          rd_next,
    output logic                        release_en,
    output logic [`PAGE_W-1:0]          release_page,
    input  logic [`NUM_PORTS-1:0]       ready,
    output logic [`NUM_PORTS-1:0]       rd_sop,
    output logic [`NUM_PORTS-1:0]       rd_eop,
    output logic [`NUM_PORTS-1:0]       rd_vld,
    output logic [`NUM_PORTS-1:0][15:0] rd_data_out,
    output logic [15:0]                 ecc_fix_cnt
);
    localparam int QW = $clog2(`DESC_DEPTH);

    rd_state_t             state;
    pkt_desc_t             q_mem [`NUM_PORTS][`DESC_DEPTH];
    logic [QW:0]           q_wr [`NUM_PORTS];
    logic [QW:0]           q_rd [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] q_busy;
    logic [`PORT_W:0]      pick;
    logic [`PORT_W-1:0]    pick_port;
    pkt_desc_t             head_desc;
    logic [`PORT_W-1:0]    rr_ptr;
    logic [`PORT_W-1:0]    out_port;
    logic [`PAGE_W-1:0]    cur_page;
    logic [`PAGE_W-1:0]    next_q;
    logic [8:0]            remain;
    logic [2:0]            widx;
    logic                  first_word;
    page_t                 fixed;
    page_t                 page_q;
    logic                  corrected;
    logic                  send;
    logic                  page_done;

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_queue
        assign q_busy[i]  = q_wr[i] != q_rd[i];
        assign dq.room[i] = (q_wr[i] - q_rd[i]) != (QW+1)'(`DESC_DEPTH);
        assign rd_vld[i]  = send && (out_port == i);
        assign rd_sop[i]  = rd_vld[i] && first_word;
        assign rd_eop[i]  = rd_vld[i] && (remain == 9'd1);
        assign rd_data_out[i] = page_q[widx];
    end

    assign pick      = rr_pick(q_busy, rr_ptr);
    assign pick_port = pick[`PORT_W-1:0];
    assign head_desc = q_mem[pick_port][q_rd[pick_port][QW-1:0]];

    assign rd_page      = cur_page;
    assign send         = (state == R_SEND) && ready[out_port];
    assign page_done    = send && (remain == 9'd1 || widx == 3'(`PAGE_WORDS - 1));
    assign release_en   = page_done;
    assign release_page = cur_page;

    ecc_decoder u_ecc_decoder (
        .data      (rd_data),
        .code      (rd_code),
        .fixed     (fixed),
        .corrected (corrected)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                q_wr[p] <= '0;
                q_rd[p] <= '0;
            end
            state       <= R_IDLE;
            rr_ptr      <= '0;
            ecc_fix_cnt <= '0;
        end else begin
            if (dq.push) begin
                q_wr[dq.desc.dest] <= q_wr[dq.desc.dest] + 1'b1;
            end
            case (state)
                R_IDLE: begin
                    if (pick[`PORT_W]) begin
                        q_rd[pick_port] <= q_rd[pick_port] + 1'b1;
                        rr_ptr          <= pick_port + 1'b1;
                        state           <= R_FETCH;
                    end
                end
                R_FETCH: state <= R_CHECK;
                R_CHECK: begin
                    ecc_fix_cnt <= ecc_fix_cnt + 16'(corrected);
                    state       <= R_SEND;
                end
                R_SEND: begin
                    // next page of the chain, or back to idle at packet end
                    if (page_done) begin
                        state <= (remain == 9'd1) ? R_IDLE : R_FETCH;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dq.push) begin
            q_mem[dq.desc.dest][q_wr[dq.desc.dest][QW-1:0]] <= dq.desc;
        end
        if (state == R_IDLE && pick[`PORT_W]) begin
            cur_page   <= head_desc.head_page;
            remain     <= head_desc.length;
            out_port   <= pick_port;
            widx       <= '0;
            first_word <= 1'b1;
        end
        if (state == R_CHECK) begin
            page_q <= fixed;
            next_q <= rd_next;
        end
        if (send) begin
            remain     <= remain - 9'd1;
            widx       <= widx + 3'd1;
            first_word <= 1'b0;
            if (page_done) begin
                cur_page <= next_q;
            end
        end
    end

endmodule

//--- rtl/switch_top.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module switch_top
    import switch_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`NUM_PORTS-1:0]       wr_sop,
    input  logic [`NUM_PORTS-1:0]       wr_eop,
    input  logic [`NUM_PORTS-1:0]       wr_vld,
    input  logic [`NUM_PORTS-1:0][15:0] wr_data,
    output logic [`NUM_PORTS-1:0]       full,
    input  logic [`NUM_PORTS-1:0]       ready,
    output logic [`NUM_PORTS-1:0]       rd_sop,
    output logic [`NUM_PORTS-1:0]       rd_eop,
    output logic [`NUM_PORTS-1:0]       rd_vld,
    output logic [`NUM_PORTS-1:0][15:0] rd_data,
    input  logic                        err_inject,
    output logic [15:0]                 ecc_fix_cnt
);
    logic               alloc;
    logic [`PAGE_W-1:0] alloc_page;
    logic [`PAGE_W:0]   free_cnt;
    logic               space_low;
    logic               wr_en;
    logic [`PAGE_W-1:0] wr_page;
    page_t              st_wr_data;
    logic [7:0]         wr_code;
    logic               link_en;
    logic [`PAGE_W-1:0] link_from;
    logic [`PAGE_W-1:0] link_to;
    logic [`PAGE_W-1:0] rd_page;
    page_t              st_rd_data;
    logic [7:0]         rd_code;
    logic [`PAGE_W-1:0] rd_next;
    logic               release_en;
    logic [`PAGE_W-1:0] release_page;

    page_if pg_bus [`NUM_PORTS] ();
    desc_if dq_bus ();

    // room for one maximum-size packet
    assign space_low = free_cnt < (`PAGE_W+1)'(`MAX_PKT_WORDS / `PAGE_WORDS);

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_front
        port_frontend u_port_frontend (
            .clk       (clk),
            .rst       (rst),
            .wr_sop    (wr_sop[i]),
            .wr_eop    (wr_eop[i]),
            .wr_vld    (wr_vld[i]),
            .wr_data   (wr_data[i]),
            .full      (full[i]),
            .pg        (pg_bus[i]),
            .space_low (space_low)
        );
    end

    page_writer u_page_writer (
        .clk, .rst,
        .pg         (pg_bus),
        .alloc, .alloc_page, .free_cnt,
        .wr_en, .wr_page,
        .wr_data    (st_wr_data),
        .wr_code, .link_en, .link_from, .link_to,
        .dq         (dq_bus),
        .err_inject
    );

    page_store u_page_store (
        .clk, .rst,
        .alloc, .alloc_page, .free_cnt,
        .wr_en, .wr_page,
        .wr_data    (st_wr_data),
        .wr_code, .link_en, .link_from, .link_to,
        .rd_page,
        .rd_data    (st_rd_data),
        .rd_code, .rd_next,
        .release_en, .release_page
    );

    page_reader u_page_reader (
        .clk, .rst,
        .dq          (dq_bus),
        .rd_page,
        .rd_data     (st_rd_data),
        .rd_code, .rd_next,
        .release_en, .release_page,
        .ready, .rd_sop, .rd_eop, .rd_vld,
        .rd_data_out (rd_data),
        .ecc_fix_cnt
    );

endmodule

//--- test/switch_tb.sv
`timescale 1ns/100ps
`include "switch_defines.svh"

module switch_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int SINGLE_PKTS  = 8;
    localparam int MIXED_ROUNDS = 3;
    localparam int BP_ROUNDS    = 2;
    localparam int ROUND_PKTS   = 2;
    localparam int ECC_PKTS     = 4;
    localparam int BURST_PKTS   = 9;
    // upper bound on the words sent over the whole run
    localparam int MAX_WORDS = `MAX_PKT_WORDS * (SINGLE_PKTS + ECC_PKTS + BURST_PKTS
        + (MIXED_ROUNDS + BP_ROUNDS) * ROUND_PKTS * `NUM_PORTS);
    localparam int WATCHDOG_CYCLES = MAX_WORDS * 64;

    logic                        clk;
    logic                        rst;
    logic [`NUM_PORTS-1:0]       wr_sop;
    logic [`NUM_PORTS-1:0]       wr_eop;
    logic [`NUM_PORTS-1:0]       wr_vld;
    logic [`NUM_PORTS-1:0][15:0] wr_data;
    logic [`NUM_PORTS-1:0]       full;
    logic [`NUM_PORTS-1:0]       ready;
    logic [`NUM_PORTS-1:0]       rd_sop;
    logic [`NUM_PORTS-1:0]       rd_eop;
    logic [`NUM_PORTS-1:0]       rd_vld;
    logic [`NUM_PORTS-1:0][15:0] rd_data;
    logic                        err_inject;
    logic [15:0]                 ecc_fix_cnt;

    // expected output words as {sop, eop, data}
    logic [17:0]           exp_q [`NUM_PORTS][$];
    logic [17:0]           exp_head [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] exp_valid;
    int                    words_sent;
    int                    words_recv;
    string                 test_name;
    int                    ready_mode;
    logic [`NUM_PORTS-1:0] ready_block;
    logic                  burst_done;

    switch_top u_switch_top (
        .clk         (clk),
        .rst         (rst),
        .wr_sop      (wr_sop),
        .wr_eop      (wr_eop),
        .wr_vld      (wr_vld),
        .wr_data     (wr_data),
        .full        (full),
        .ready       (ready),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_vld      (rd_vld),
        .rd_data     (rd_data),
        .err_inject  (err_inject),
        .ecc_fix_cnt (ecc_fix_cnt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    function automatic void refresh_heads();
        for (int p = 0; p < `NUM_PORTS; p++) begin
            exp_valid[p] = exp_q[p].size() != 0;
            exp_head[p]  = exp_valid[p] ? exp_q[p][0] : '0;
        end
    endfunction

    // 0 keeps ready high, 1 gives about half the cycles, 2 about a quarter
    initial begin
        forever begin
            @(posedge clk);
            #2;
            case (ready_mode)
                1: ready = (`NUM_PORTS)'($urandom) & ~ready_block;
                2: ready = (`NUM_PORTS)'($urandom & $urandom) & ~ready_block;
                default: ready = ~ready_block;
            endcase
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                if (rd_vld[p]) begin
                    words_recv++;
                    if (exp_q[p].size() != 0) begin
                        void'(exp_q[p].pop_front());
                    end
                end
            end
            refresh_heads();
        end
    end

    for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_check
        a_word_expected: assert property (@(posedge clk) disable iff (rst)
            rd_vld[p] |-> exp_valid[p])
            else fail_now($sformatf("word on output %0d with no packet pending", p));

        a_word_match: assert property (@(posedge clk) disable iff (rst)
            rd_vld[p] && exp_valid[p] |-> {rd_sop[p], rd_eop[p], rd_data[p]} == exp_head[p])
            else fail_now($sformatf("MISMATCH %s port %0d expected %05h actual %05h",
                test_name, p, $sampled(exp_head[p]),
                {$sampled(rd_sop[p]), $sampled(rd_eop[p]), $sampled(rd_data[p])}));

        a_vld_needs_ready: assert property (@(posedge clk) disable iff (rst)
            rd_vld[p] |-> ready[p])
            else fail_now($sformatf("rd_vld high on output %0d while ready is low", p));
    end

    // header is length [15:7], priority [6:4], dest [3:0]
    task automatic send_packet(input int port, input int dest, input int len);
        logic [15:0] words [$];
        words.push_back({9'(len), 3'($urandom), 4'(dest)});
        for (int i = 1; i < len; i++) begin
            words.push_back(16'($urandom));
        end
        for (int i = 0; i < len; i++) begin
            while (full[port]) begin
                wr_vld[port] = 1'b0;
                @(posedge clk);
                #2;
            end
            wr_vld[port]  = 1'b1;
            wr_sop[port]  = (i == 0);
            wr_eop[port]  = (i == len - 1);
            wr_data[port] = words[i];
            @(posedge clk);
            #2;
        end
        wr_vld[port] = 1'b0;
        wr_sop[port] = 1'b0;
        wr_eop[port] = 1'b0;
        for (int i = 0; i < len; i++) begin
            exp_q[dest].push_back({i == 0, i == len - 1, words[i]});
        end
        words_sent += len;
        refresh_heads();
    endtask

    task automatic send_stream(input int port, input int dest, input int n_pkts);
        int gap;
        for (int k = 0; k < n_pkts; k++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            send_packet(port, dest, 1 + $urandom % `MAX_PKT_WORDS);
        end
    endtask

    task automatic wait_drain();
        while (exp_valid != '0) begin
            @(posedge clk);
            #2;
        end
        repeat (4) begin
            @(posedge clk);
        end
        #2;
    endtask

    // each input feeds its own output and the mapping rotates per round
    task automatic mixed_round(input int n_pkts);
        int rot;
        rot = $urandom % `NUM_PORTS;
        fork
            send_stream(0, (0 + rot) % `NUM_PORTS, n_pkts);
            send_stream(1, (1 + rot) % `NUM_PORTS, n_pkts);
            send_stream(2, (2 + rot) % `NUM_PORTS, n_pkts);
            send_stream(3, (3 + rot) % `NUM_PORTS, n_pkts);
        join
        wait_drain();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) begin
            @(posedge clk);
        end
        fail_now($sformatf("watchdog expired after %0d cycles, traffic still pending",
            WATCHDOG_CYCLES));
    end

    initial begin
        int len;
        int pages;
        int fix_before;
        void'($urandom(66));
        rst         = 1'b1;
        wr_sop      = '0;
        wr_eop      = '0;
        wr_vld      = '0;
        wr_data     = '0;
        ready       = '0;
        err_inject  = 1'b0;
        ready_mode  = 0;
        ready_block = '0;
        burst_done  = 1'b0;
        words_sent  = 0;
        words_recv  = 0;
        test_name   = "reset";
        refresh_heads();
        repeat (4) begin
            @(posedge clk);
        end
        #2;
        rst = 1'b0;

        test_name = "idle_after_reset";
        repeat (20) begin
            @(posedge clk);
            #2;
            assert (rd_vld == '0 && full == '0)
                else fail_now("rd_vld or full high with no traffic");
        end

        test_name = "single_packet";
        for (int k = 0; k < SINGLE_PKTS; k++) begin
            case (k)
                0: len = 1;
                1: len = 8;
                2: len = 9;
                3: len = `MAX_PKT_WORDS;
                default: len = 1 + $urandom % `MAX_PKT_WORDS;
            endcase
            send_packet($urandom % `NUM_PORTS, $urandom % `NUM_PORTS, len);
            wait_drain();
        end

        test_name  = "mixed_traffic";
        ready_mode = 1;
        for (int r = 0; r < MIXED_ROUNDS; r++) begin
            mixed_round(ROUND_PKTS);
        end

        test_name  = "backpressure";
        ready_mode = 2;
        for (int r = 0; r < BP_ROUNDS; r++) begin
            mixed_round(ROUND_PKTS);
        end
        assert (words_recv == words_sent)
            else fail_now($sformatf("MISMATCH %s expected %0d words actual %0d words",
                test_name, words_sent, words_recv));

        test_name  = "ecc_correction";
        ready_mode = 0;
        fix_before = ecc_fix_cnt;
        pages      = 0;
        err_inject = 1'b1;
        for (int k = 0; k < ECC_PKTS; k++) begin
            len   = 1 + $urandom % `MAX_PKT_WORDS;
            pages += (len + `PAGE_WORDS - 1) / `PAGE_WORDS;
            send_packet(3, $urandom % `NUM_PORTS, len);
        end
        wait_drain();
        err_inject = 1'b0;
        assert (ecc_fix_cnt == 16'(fix_before + pages))
            else fail_now($sformatf("MISMATCH %s expected %0d actual %0d",
                test_name, fix_before + pages, ecc_fix_cnt));

        // output 2 is held off until the input reports full
        test_name   = "burst_full";
        ready_block = 4'b0100;
        repeat (2) begin
            @(posedge clk);
        end
        #2;
        fork
            begin
                for (int k = 0; k < BURST_PKTS; k++) begin
                    send_packet(1, 2, `MAX_PKT_WORDS);
                end
                burst_done = 1'b1;
            end
            begin
                while (!full[1] && !burst_done) begin
                    @(posedge clk);
                    #2;
                end
                assert (full[1]) else fail_now("full never rose during the burst");
                ready_block = '0;
            end
        join
        wait_drain();
        assert (full == '0) else fail_now("full still high after the output drained");

        test_name = "end";
        repeat (10) begin
            @(posedge clk);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- switch.f
+incdir+common
common/switch_pkg.sv
common/switch_ifs.sv
frontend/port_frontend.sv
ecc/ecc_encoder.sv
ecc/ecc_decoder.sv
rtl/page_store.sv
rtl/page_writer.sv
rtl/page_reader.sv
rtl/switch_top.sv
test/switch_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of switch_tb
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module switch_tb \
    -f switch.f -o switch_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/switch_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
